//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // Widths and depths
  localparam int XLEN_W    = 32;
  localparam int XLEN_B    = XLEN_W / 8;
  localparam int ADDR_W    = 8;
  localparam int LANE_W    = 2;
  localparam int WADDR_W   = ADDR_W - LANE_W;
  localparam int RAM_WORDS = 64;
  localparam int ROB_ID_W  = 4;
  localparam int OFFSET_W  = 12;
  localparam int STB_DEPTH = 4;
  localparam int STB_PTR_W = $clog2(STB_DEPTH);
  localparam int STB_CNT_W = $clog2(STB_DEPTH + 1);

  typedef enum logic [2:0] {
    LSU_LB  = 3'd0,
    LSU_LBU = 3'd1,
    LSU_LW  = 3'd2,
    LSU_SB  = 3'd3,
    LSU_SW  = 3'd4
  } lsu_op_e;

  // Instruction as handed over by dispatch, operands already read
  typedef struct packed {
    lsu_op_e               op;
    logic [ROB_ID_W-1:0]   rob_id;
    logic [XLEN_W-1:0]     base;
    logic [OFFSET_W-1:0]   offset;
    logic [XLEN_W-1:0]     st_data;
  } disp_inst_t;

  typedef struct packed {
    logic                  valid;
    lsu_op_e               op;
    logic [ROB_ID_W-1:0]   rob_id;
    logic [ADDR_W-1:0]     addr;
    logic                  misaligned;
    logic [XLEN_W-1:0]     st_data;
  } ex_req_t;

  typedef struct packed {
    logic                  valid;
    lsu_op_e               op;
    logic [ROB_ID_W-1:0]   rob_id;
    logic                  misaligned;
    logic [LANE_W-1:0]     lane;
    logic [XLEN_B-1:0]     fwd_mask;
    logic [XLEN_W-1:0]     fwd_data;
  } rd_req_t;

  typedef struct packed {
    logic [WADDR_W-1:0]    waddr;
    logic [XLEN_B-1:0]     be;
    logic [XLEN_W-1:0]     data;
    logic                  committed;
  } stb_entry_t;

  typedef struct packed {
    logic                  valid;
    logic [ROB_ID_W-1:0]   rob_id;
    logic                  is_store;
    logic                  except;
    logic [XLEN_W-1:0]     data;
  } done_rpt_t;

endpackage

`default_nettype wire

//--- hw/lsu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_decode (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_disp_valid,
  input  lsu_pkg::disp_inst_t i_disp,
  output lsu_pkg::ex_req_t    o_ex_req
);

  logic [lsu_pkg::XLEN_W-1:0] w_eff_addr;
  logic [lsu_pkg::ADDR_W-1:0] w_addr;
  logic                       w_is_word;
  logic                       w_misaligned;

  // Base plus sign-extended offset, only the low bits reach the RAM
  assign w_eff_addr = i_disp.base +
                      {{(lsu_pkg::XLEN_W - lsu_pkg::OFFSET_W){i_disp.offset[lsu_pkg::OFFSET_W-1]}},
                       i_disp.offset};
  assign w_addr     = w_eff_addr[lsu_pkg::ADDR_W-1:0];

  assign w_is_word    = (i_disp.op == lsu_pkg::LSU_LW) || (i_disp.op == lsu_pkg::LSU_SW);
  assign w_misaligned = w_is_word && (w_addr[lsu_pkg::LANE_W-1:0] != '0);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex_req <= '0;
    end else begin
      o_ex_req.valid      <= i_disp_valid;
      o_ex_req.op         <= i_disp.op;
      o_ex_req.rob_id     <= i_disp.rob_id;
      o_ex_req.addr       <= w_addr;
      o_ex_req.misaligned <= w_misaligned;
      o_ex_req.st_data    <= i_disp.st_data;
    end
  end

  // Only defined opcodes may enter the pipe
  a_legal_op : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |=> (o_ex_req.op inside {lsu_pkg::LSU_LB, lsu_pkg::LSU_LBU, lsu_pkg::LSU_LW,
                                          lsu_pkg::LSU_SB, lsu_pkg::LSU_SW})
  );

endmodule

`default_nettype wire

//--- hw/lsu_store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_store_buffer (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  logic                            i_push,
  input  lsu_pkg::stb_entry_t             i_push_entry,
  input  logic                            i_commit,
  input  logic [lsu_pkg::WADDR_W-1:0]     i_ld_word_addr,
  output logic [lsu_pkg::XLEN_B-1:0]      o_fwd_mask,
  output logic [lsu_pkg::XLEN_W-1:0]      o_fwd_data,
  output logic [lsu_pkg::STB_CNT_W-1:0]   o_free_cnt,
  output logic                            o_ram_wr_en,
  output logic [lsu_pkg::WADDR_W-1:0]     o_ram_wr_addr,
  output logic [lsu_pkg::XLEN_B-1:0]      o_ram_wr_be,
  output logic [lsu_pkg::XLEN_W-1:0]      o_ram_wr_data
);

  lsu_pkg::stb_entry_t                r_entries [lsu_pkg::STB_DEPTH];
  logic [lsu_pkg::STB_DEPTH-1:0]      r_valid;
  logic [lsu_pkg::STB_PTR_W-1:0]      r_head;
  logic [lsu_pkg::STB_PTR_W-1:0]      r_tail;
  logic [lsu_pkg::STB_PTR_W-1:0]      r_cmt_ptr;
  logic [lsu_pkg::STB_CNT_W-1:0]      r_pend_cnt;

  logic w_drain;
  logic w_uncmt_avail;
  logic w_cmt_req;
  logic w_cmt_entry;
  logic w_cmt_push;

  // ------------------------------------------------------------------------
  // Commit and drain control
  // ------------------------------------------------------------------------
  assign w_drain       = r_valid[r_head] && r_entries[r_head].committed;
  // Commit pointer rests on the oldest uncommitted entry, or on the tail
  assign w_uncmt_avail = r_valid[r_cmt_ptr] && !r_entries[r_cmt_ptr].committed;
  assign w_cmt_req     = i_commit || (r_pend_cnt != '0);
  assign w_cmt_entry   = w_cmt_req && w_uncmt_avail;
  // Early commit lands on the store being pushed right now
  assign w_cmt_push    = w_cmt_req && !w_uncmt_avail && i_push;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid    <= '0;
      r_head     <= '0;
      r_tail     <= '0;
      r_cmt_ptr  <= '0;
      r_pend_cnt <= '0;
    end else begin
      if (i_push) begin
        r_valid[r_tail] <= 1'b1;
        r_tail          <= r_tail + 1'b1;
      end
      if (w_drain) begin
        r_valid[r_head] <= 1'b0;
        r_head          <= r_head + 1'b1;
      end
      if (w_cmt_entry || w_cmt_push) begin
        r_cmt_ptr <= r_cmt_ptr + 1'b1;
      end
      r_pend_cnt <= r_pend_cnt + lsu_pkg::STB_CNT_W'(i_commit)
                    - lsu_pkg::STB_CNT_W'(w_cmt_entry || w_cmt_push);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_entries[r_tail]           <= i_push_entry;
      r_entries[r_tail].committed <= w_cmt_push;
    end
    if (w_cmt_entry) begin
      r_entries[r_cmt_ptr].committed <= 1'b1;
    end
  end

  assign o_ram_wr_en   = w_drain;
  assign o_ram_wr_addr = r_entries[r_head].waddr;
  assign o_ram_wr_be   = r_entries[r_head].be;
  assign o_ram_wr_data = r_entries[r_head].data;

  always_comb begin
    o_free_cnt = lsu_pkg::STB_CNT_W'(lsu_pkg::STB_DEPTH);
    for (int i = 0; i < lsu_pkg::STB_DEPTH; i++) begin
      if (r_valid[i]) begin
        o_free_cnt = o_free_cnt - 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Forwarding, walked oldest to youngest so the youngest byte wins
  // ------------------------------------------------------------------------
  always_comb begin
    logic [lsu_pkg::STB_PTR_W-1:0] idx;
    o_fwd_mask = '0;
    o_fwd_data = '0;
    for (int k = 0; k < lsu_pkg::STB_DEPTH; k++) begin
      idx = r_head + lsu_pkg::STB_PTR_W'(k);
      if (r_valid[idx] && (r_entries[idx].waddr == i_ld_word_addr)) begin
        for (int b = 0; b < lsu_pkg::XLEN_B; b++) begin
          if (r_entries[idx].be[b]) begin
            o_fwd_mask[b]        = 1'b1;
            o_fwd_data[b*8 +: 8] = r_entries[idx].data[b*8 +: 8];
          end
        end
      end
    end
  end

  a_no_push_full : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_push |-> !r_valid[r_tail]
  );

  // Only the execute-stage store and the one being dispatched run ahead of a commit
  a_pend_bound : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_pend_cnt <= lsu_pkg::STB_CNT_W'(2)
  );

endmodule

`default_nettype wire

//--- hw/lsu_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram (
  input  logic                        i_clk,
  input  logic [lsu_pkg::WADDR_W-1:0] i_rd_addr,
  output logic [lsu_pkg::XLEN_W-1:0]  o_rd_data,
  input  logic                        i_wr_en,
  input  logic [lsu_pkg::WADDR_W-1:0] i_wr_addr,
  input  logic [lsu_pkg::XLEN_B-1:0]  i_wr_be,
  input  logic [lsu_pkg::XLEN_W-1:0]  i_wr_data
);

  logic [lsu_pkg::XLEN_W-1:0] r_mem [lsu_pkg::RAM_WORDS];

  // Read sees the word as it was before a write on the same edge
  always_ff @(posedge i_clk) begin
    o_rd_data <= r_mem[i_rd_addr];
  end

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < lsu_pkg::XLEN_B; b++) begin
        if (i_wr_be[b]) begin
          r_mem[i_wr_addr][b*8 +: 8] <= i_wr_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_execute (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  lsu_pkg::ex_req_t           i_ex_req,
  input  logic                       i_commit,
  output lsu_pkg::rd_req_t           o_rd_req,
  output logic [lsu_pkg::XLEN_W-1:0] o_ram_rd_data,
  output logic                       o_disp_ready
);

  logic [lsu_pkg::WADDR_W-1:0]   w_word_addr;
  logic [lsu_pkg::LANE_W-1:0]    w_lane;
  logic                          w_is_store;
  logic                          w_is_load;
  logic                          w_push;
  lsu_pkg::stb_entry_t           w_push_entry;
  logic [lsu_pkg::XLEN_B-1:0]    w_fwd_mask;
  logic [lsu_pkg::XLEN_W-1:0]    w_fwd_data;
  logic [lsu_pkg::STB_CNT_W-1:0] w_free_cnt;
  logic                          w_ram_wr_en;
  logic [lsu_pkg::WADDR_W-1:0]   w_ram_wr_addr;
  logic [lsu_pkg::XLEN_B-1:0]    w_ram_wr_be;
  logic [lsu_pkg::XLEN_W-1:0]    w_ram_wr_data;

  assign w_word_addr = i_ex_req.addr[lsu_pkg::ADDR_W-1:lsu_pkg::LANE_W];
  assign w_lane      = i_ex_req.addr[lsu_pkg::LANE_W-1:0];
  assign w_is_store  = i_ex_req.valid &&
                       ((i_ex_req.op == lsu_pkg::LSU_SB) || (i_ex_req.op == lsu_pkg::LSU_SW));
  assign w_is_load   = i_ex_req.valid && !w_is_store;
  // Misaligned stores only report, memory stays untouched
  assign w_push      = w_is_store && !i_ex_req.misaligned;

  always_comb begin
    w_push_entry       = '0;
    w_push_entry.waddr = w_word_addr;
    if (i_ex_req.op == lsu_pkg::LSU_SB) begin
      w_push_entry.be   = lsu_pkg::XLEN_B'(1) << w_lane;
      w_push_entry.data = {24'd0, i_ex_req.st_data[7:0]} << {w_lane, 3'b000};
    end else begin
      w_push_entry.be   = '1;
      w_push_entry.data = i_ex_req.st_data;
    end
  end

  // Room must remain for the store now in execute plus one more
  assign o_disp_ready = w_free_cnt > lsu_pkg::STB_CNT_W'(w_is_store);

  lsu_store_buffer u_store_buffer (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_push         (w_push),
    .i_push_entry   (w_push_entry),
    .i_commit       (i_commit),
    .i_ld_word_addr (w_word_addr),
    .o_fwd_mask     (w_fwd_mask),
    .o_fwd_data     (w_fwd_data),
    .o_free_cnt     (w_free_cnt),
    .o_ram_wr_en    (w_ram_wr_en),
    .o_ram_wr_addr  (w_ram_wr_addr),
    .o_ram_wr_be    (w_ram_wr_be),
    .o_ram_wr_data  (w_ram_wr_data)
  );

  lsu_data_ram u_data_ram (
    .i_clk     (i_clk),
    .i_rd_addr (w_word_addr),
    .o_rd_data (o_ram_rd_data),
    .i_wr_en   (w_ram_wr_en),
    .i_wr_addr (w_ram_wr_addr),
    .i_wr_be   (w_ram_wr_be),
    .i_wr_data (w_ram_wr_data)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_rd_req <= '0;
    end else begin
      o_rd_req.valid      <= i_ex_req.valid;
      o_rd_req.op         <= i_ex_req.op;
      o_rd_req.rob_id     <= i_ex_req.rob_id;
      o_rd_req.misaligned <= i_ex_req.misaligned;
      o_rd_req.lane       <= w_lane;
      o_rd_req.fwd_mask   <= w_is_load ? w_fwd_mask : '0;
      o_rd_req.fwd_data   <= w_fwd_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_result.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_result (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  lsu_pkg::rd_req_t           i_rd_req,
  input  logic [lsu_pkg::XLEN_W-1:0] i_ram_rd_data,
  output lsu_pkg::done_rpt_t         o_done
);

  logic [lsu_pkg::XLEN_W-1:0] w_merged;
  logic [7:0]                 w_byte;
  logic [lsu_pkg::XLEN_W-1:0] w_ld_data;
  logic                       w_is_load;
  logic                       w_is_store;
  lsu_pkg::done_rpt_t         w_ld_rpt;
  lsu_pkg::done_rpt_t         w_st_rpt;

  // Forwarded bytes override the RAM word
  always_comb begin
    for (int b = 0; b < lsu_pkg::XLEN_B; b++) begin
      w_merged[b*8 +: 8] = i_rd_req.fwd_mask[b] ? i_rd_req.fwd_data[b*8 +: 8]
                                                : i_ram_rd_data[b*8 +: 8];
    end
  end

  assign w_byte = w_merged[{i_rd_req.lane, 3'b000} +: 8];

  always_comb begin
    case (i_rd_req.op)
      lsu_pkg::LSU_LB:  w_ld_data = {{(lsu_pkg::XLEN_W-8){w_byte[7]}}, w_byte};
      lsu_pkg::LSU_LBU: w_ld_data = {{(lsu_pkg::XLEN_W-8){1'b0}}, w_byte};
      default:          w_ld_data = w_merged;
    endcase
  end

  assign w_is_load  = (i_rd_req.op == lsu_pkg::LSU_LB) || (i_rd_req.op == lsu_pkg::LSU_LBU) ||
                      (i_rd_req.op == lsu_pkg::LSU_LW);
  assign w_is_store = (i_rd_req.op == lsu_pkg::LSU_SB) || (i_rd_req.op == lsu_pkg::LSU_SW);

  // ------------------------------------------------------------------------
  // Load and store reports
  // ------------------------------------------------------------------------
  always_comb begin
    w_ld_rpt          = '0;
    w_ld_rpt.valid    = i_rd_req.valid && w_is_load;
    w_ld_rpt.rob_id   = i_rd_req.rob_id;
    w_ld_rpt.except   = i_rd_req.misaligned;
    w_ld_rpt.data     = i_rd_req.misaligned ? '0 : w_ld_data;

    w_st_rpt          = '0;
    w_st_rpt.valid    = i_rd_req.valid && w_is_store;
    w_st_rpt.rob_id   = i_rd_req.rob_id;
    w_st_rpt.is_store = 1'b1;
    w_st_rpt.except   = i_rd_req.misaligned;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_done <= '0;
    end else begin
      o_done <= w_ld_rpt.valid ? w_ld_rpt : w_st_rpt;
    end
  end

  a_one_report : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    !(w_ld_rpt.valid && w_st_rpt.valid)
  );

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_disp_valid,
  input  lsu_pkg::disp_inst_t i_disp,
  output logic                o_disp_ready,
  input  logic                i_commit,
  output lsu_pkg::done_rpt_t  o_done
);

  lsu_pkg::ex_req_t           w_ex_req;
  lsu_pkg::rd_req_t           w_rd_req;
  logic [lsu_pkg::XLEN_W-1:0] w_ram_rd_data;

  // Decode, then execute with store buffer and RAM, then report merge
  lsu_decode u_decode (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_disp       (i_disp),
    .o_ex_req     (w_ex_req)
  );

  lsu_execute u_execute (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_ex_req      (w_ex_req),
    .i_commit      (i_commit),
    .o_rd_req      (w_rd_req),
    .o_ram_rd_data (w_ram_rd_data),
    .o_disp_ready  (o_disp_ready)
  );

  lsu_result u_result (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rd_req      (w_rd_req),
    .i_ram_rd_data (w_ram_rd_data),
    .o_done        (o_done)
  );

endmodule

`default_nettype wire

//--- include/tb_lsu_util.svh
`ifndef TB_LSU_UTIL_SVH
`define TB_LSU_UTIL_SVH

// One step of a 32-bit Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] shifted;
  shifted = state >> 1;
  if (state[0]) begin
    shifted = shifted ^ 32'h8020_0003;
  end
  return shifted;
endfunction

// Stops the run at the first report field that differs
task automatic compare_field(
  input string       name,
  input logic [31:0] expected,
  input logic [31:0] actual
);
  if (actual !== expected) begin
    $display("error: %s expected %08h actual %08h", name, expected, actual);
    abort_run("done report field mismatch");
  end
endtask

`endif

//--- tests/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

  localparam int N_OPS         = 600;
  localparam int MAIN_TIMEOUT  = 20000;
  localparam int WAIT_TIMEOUT  = 200;

  typedef struct packed {
    lsu_pkg::done_rpt_t rpt;
    logic [31:0]        mask;
    logic [31:0]        due;
  } exp_t;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_disp_valid;
  lsu_pkg::disp_inst_t i_disp;
  logic                o_disp_ready;
  logic                i_commit;
  lsu_pkg::done_rpt_t  o_done;

  // Reference model, 16 words as bytes plus a written flag per byte
  logic [7:0]  mem_b [64];
  logic        mem_w [64];
  exp_t        exp_q [$];
  logic [31:0] lfsr_state;
  logic [3:0]  rob_ctr;
  logic        saw_stall;
  int          cyc;
  int          n_sent;
  int          uncmt;
  string       test_name;

  `include "tb_lsu_util.svh"

  lsu_top uut (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_disp       (i_disp),
    .o_disp_ready (o_disp_ready),
    .i_commit     (i_commit),
    .o_done       (o_done)
  );

  always #10 i_clk = ~i_clk;

  task automatic abort_run(input string msg);
    $display("TEST FAILED");
    $fatal(1, "%s", msg);
  endtask

  // Takes bit 0 of the LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r          = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  // A report is due exactly three falling edges after its dispatch was driven
  task automatic check_done();
    exp_t e;
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      if (o_done.valid !== 1'b1) begin
        abort_run("expected done report did not arrive on time");
      end else begin
        compare_field({test_name, " rob_id"}, 32'(e.rpt.rob_id), 32'(o_done.rob_id));
        compare_field({test_name, " is_store"}, 32'(e.rpt.is_store), 32'(o_done.is_store));
        compare_field({test_name, " except"}, 32'(e.rpt.except), 32'(o_done.except));
        compare_field({test_name, " data"}, e.rpt.data & e.mask, o_done.data & e.mask);
      end
    end else if (o_done.valid !== 1'b0) begin
      abort_run("done report appeared without a matching dispatch");
    end
  endtask

  task automatic next_cycle();
    @(negedge i_clk);
    cyc++;
    check_done();
    i_disp_valid = 1'b0;
    i_commit     = 1'b0;
  endtask

  task automatic send_inst(input lsu_pkg::lsu_op_e op, input logic [5:0] baddr,
                           input logic [31:0] st_data);
    logic [11:0] off;
    logic [31:0] sext_off;
    logic        mis;
    logic [7:0]  bv;
    exp_t        e;
    off      = 12'(rand_bits(12));
    sext_off = {{20{off[11]}}, off};
    mis      = (op == lsu_pkg::LSU_LW || op == lsu_pkg::LSU_SW) && (baddr[1:0] != 2'd0);
    i_disp_valid   = 1'b1;
    i_disp.op      = op;
    i_disp.rob_id  = rob_ctr;
    i_disp.base    = {26'd0, baddr} - sext_off;
    i_disp.offset  = off;
    i_disp.st_data = st_data;
    e = '0;
    e.rpt.valid    = 1'b1;
    e.rpt.rob_id   = rob_ctr;
    e.rpt.is_store = (op == lsu_pkg::LSU_SB || op == lsu_pkg::LSU_SW);
    e.rpt.except   = mis;
    e.mask         = '1;
    e.due          = 32'(cyc + 3);
    bv             = mem_b[baddr];
    if (!mis) begin
      case (op)
        lsu_pkg::LSU_SB: begin
          mem_b[baddr] = st_data[7:0];
          mem_w[baddr] = 1'b1;
          uncmt++;
        end
        lsu_pkg::LSU_SW: begin
          for (int b = 0; b < 4; b++) begin
            mem_b[{baddr[5:2], 2'(b)}] = st_data[b*8 +: 8];
            mem_w[{baddr[5:2], 2'(b)}] = 1'b1;
          end
          uncmt++;
        end
        lsu_pkg::LSU_LW: begin
          for (int b = 0; b < 4; b++) begin
            e.rpt.data[b*8 +: 8] = mem_b[{baddr[5:2], 2'(b)}];
            e.mask[b*8 +: 8]     = mem_w[{baddr[5:2], 2'(b)}] ? 8'hff : 8'h00;
          end
        end
        lsu_pkg::LSU_LB: begin
          e.rpt.data = {{24{bv[7]}}, bv};
          e.mask     = mem_w[baddr] ? 32'hffff_ffff : 32'h0;
        end
        default: begin
          // Upper bits stay zero even when the byte was never written
          e.rpt.data = {24'd0, bv};
          e.mask     = mem_w[baddr] ? 32'hffff_ffff : 32'hffff_ff00;
        end
      endcase
    end
    exp_q.push_back(e);
    rob_ctr++;
    n_sent++;
  endtask

  task automatic send_random();
    lsu_pkg::lsu_op_e op;
    logic [5:0]       baddr;
    op    = lsu_pkg::lsu_op_e'(3'(rand_bits(3) % 5));
    baddr = 6'(rand_bits(6));
    // Word ops are mostly aligned, a few stay misaligned
    if ((op == lsu_pkg::LSU_LW || op == lsu_pkg::LSU_SW) && rand_bits(3) != 0) begin
      baddr[1:0] = 2'd0;
    end
    send_inst(op, baddr, rand_bits(32));
  endtask

  initial begin
    int t;
    i_clk        = 1'b0;
    i_reset_n    = 1'b0;
    i_disp_valid = 1'b0;
    i_disp       = '0;
    i_commit     = 1'b0;
    lfsr_state   = 32'h14d683ea;
    rob_ctr      = '0;
    saw_stall    = 1'b0;
    cyc          = 0;
    n_sent       = 0;
    uncmt        = 0;
    test_name    = "random traffic";
    for (int i = 0; i < 64; i++) begin
      mem_b[i] = 8'h00;
      mem_w[i] = 1'b0;
    end
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    if (o_disp_ready !== 1'b1 || o_done.valid !== 1'b0) begin
      abort_run("outputs not at their reset values after reset");
    end

    // --------------------------------------------------------------------------
    // Random traffic, commits held back for part of every 64 cycles
    // --------------------------------------------------------------------------
    for (int c = 0; c < MAIN_TIMEOUT && n_sent < N_OPS; c++) begin
      next_cycle();
      if (!o_disp_ready) begin
        saw_stall = 1'b1;
      end
      if ((cyc % 64) < 40 && uncmt > 0 && rand_bits(1) != 0) begin
        i_commit = 1'b1;
        uncmt--;
      end
      if (o_disp_ready && rand_bits(2) != 0) begin
        send_random();
      end
    end
    if (n_sent < N_OPS) begin
      abort_run("timed out while dispatching random traffic");
    end

    // Commit the rest and let the store buffer empty
    test_name = "drain";
    t = 0;
    while ((uncmt > 0 || uut.u_execute.u_store_buffer.r_valid != '0 || exp_q.size() != 0)
           && t < WAIT_TIMEOUT) begin
      next_cycle();
      if (uncmt > 0) begin
        i_commit = 1'b1;
        uncmt--;
      end
      t++;
    end
    if (t >= WAIT_TIMEOUT) begin
      abort_run("store buffer did not drain after all commits");
    end

    // Read back every word straight from the RAM
    test_name = "readback";
    for (int w = 0; w < 16; w++) begin
      next_cycle();
      t = 0;
      while (!o_disp_ready && t < WAIT_TIMEOUT) begin
        next_cycle();
        t++;
      end
      if (!o_disp_ready) begin
        abort_run("timed out waiting for dispatch ready");
      end
      send_inst(lsu_pkg::LSU_LW, {4'(w), 2'd0}, 32'd0);
    end
    t = 0;
    while (exp_q.size() != 0 && t < WAIT_TIMEOUT) begin
      next_cycle();
      t++;
    end
    if (exp_q.size() != 0) begin
      abort_run("timed out waiting for the final load reports");
    end

    if (!saw_stall) begin
      abort_run("dispatch ready never dropped while commits were held");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/lsu_store_buffer.sv
hw/lsu_data_ram.sv
hw/lsu_execute.sv
hw/lsu_result.sv
hw/lsu_top.sv
tests/tb_lsu_top.sv

//--- Makefile
TOP := tb_lsu_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
